// File: design/mem_bridge_pkg.sv
// Shared widths of the memory bridge
// Response source tag, data-side opcodes and FSM state encodings

`default_nettype none

package mem_bridge_pkg;

    // Bus and word widths, byte addressed
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Instruction line of 16 bytes, fetched as four word beats
    localparam int LINE_BEATS  = 4;
    localparam int BEAT_W      = 2;
    localparam int LINE_ADDR_W = 28;

    // Requester tag carried with each memory transaction
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } mem_src_e;

    // Uncached data port operations
    typedef enum logic [1:0] {
        DC_LOAD   = 2'd0,
        DC_STORE  = 2'd1,
        DC_AMOADD = 2'd2
    } dc_op_e;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_REQ  = 2'd1,
        ARB_RESP = 2'd2
    } arb_state_e;

    typedef enum logic [1:0] {
        DC_IDLE = 2'd0,
        DC_RD   = 2'd1,
        DC_WR   = 2'd2,
        DC_RESP = 2'd3
    } dc_state_e;

endpackage

`default_nettype wire

// File: design/mem_port_if.sv
// Request/response link between one requester port and the arbiter
// Modports for the requester side and the arbiter side

`default_nettype none

interface mem_port_if;
    import mem_bridge_pkg::*;

    // Request channel
    logic              req_valid;
    logic              req_ready;
    logic [ADDR_W-1:0] req_addr;
    logic              req_we;
    logic [DATA_W-1:0] req_wdata;
    logic [BEAT_W-1:0] req_len;

    // Response channel, one word per beat
    logic              resp_valid;
    logic              resp_ready;
    logic [DATA_W-1:0] resp_data;
    logic              resp_last;

    modport port (
        output req_valid, req_addr, req_we, req_wdata, req_len, resp_ready,
        input  req_ready, resp_valid, resp_data, resp_last
    );

    modport arb (
        input  req_valid, req_addr, req_we, req_wdata, req_len, resp_ready,
        output req_ready, resp_valid, resp_data, resp_last
    );

endinterface

`default_nettype wire

// File: design/icache_refill_port.sv
// Instruction-cache refill port
// Miss strobe to a four-beat read burst, returned beats labelled with their index

`default_nettype none

module icache_refill_port (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   miss_valid_i,
    input  logic [mem_bridge_pkg::LINE_ADDR_W-1:0] miss_line_i,
    output logic                                   beat_valid_o,
    output logic [mem_bridge_pkg::DATA_W-1:0]      beat_data_o,
    output logic [mem_bridge_pkg::BEAT_W-1:0]      beat_idx_o,
    mem_port_if.port                               mem
);
    import mem_bridge_pkg::*;

    logic                   busy_q;
    logic                   req_valid_q;
    logic [LINE_ADDR_W-1:0] line_q;
    logic [BEAT_W-1:0]      beat_cnt_q;
    logic                   miss_take;
    logic                   beat_fire;

    assign miss_take = miss_valid_i && !busy_q;
    assign beat_fire = mem.resp_valid && mem.resp_ready;

    // Whole-line read burst at the line base address
    assign mem.req_valid  = req_valid_q;
    assign mem.req_addr   = {line_q, {(ADDR_W - LINE_ADDR_W){1'b0}}};
    assign mem.req_we     = 1'b0;
    assign mem.req_wdata  = '0;
    assign mem.req_len    = BEAT_W'(LINE_BEATS - 1);
    // Refill beats are never refused
    assign mem.resp_ready = 1'b1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            req_valid_q  <= 1'b0;
            beat_cnt_q   <= '0;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= beat_fire;
            if (miss_take) begin
                busy_q      <= 1'b1;
                req_valid_q <= 1'b1;
            end
            if (req_valid_q && mem.req_ready) begin
                req_valid_q <= 1'b0;
            end
            if (beat_fire) begin
                beat_cnt_q <= beat_cnt_q + BEAT_W'(1);
                // Line complete, ready for the next miss
                if (mem.resp_last) begin
                    busy_q     <= 1'b0;
                    beat_cnt_q <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_take) begin
            line_q <= miss_line_i;
        end
        if (beat_fire) begin
            beat_data_o <= mem.resp_data;
            beat_idx_o  <= beat_cnt_q;
        end
    end

    // The core waits for the whole line before it misses again
    a_no_miss_while_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        busy_q |-> !$rose(miss_valid_i)
    );

endmodule

`default_nettype wire

// File: design/dcache_uc_port.sv
// Uncached data port
// Sequences single-word load, store and atomic add (read then write)

`default_nettype none

module dcache_uc_port (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    input  mem_bridge_pkg::dc_op_e            req_op_i,
    input  logic [mem_bridge_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [mem_bridge_pkg::DATA_W-1:0] req_wdata_i,
    output logic                              resp_valid_o,
    input  logic                              resp_ready_i,
    output logic [mem_bridge_pkg::DATA_W-1:0] resp_rdata_o,
    mem_port_if.port                          mem
);
    import mem_bridge_pkg::*;

    dc_state_e         state_q;
    dc_op_e            op_q;
    logic              sent_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              req_fire;
    logic              resp_done;

    assign req_ready_o  = (state_q == DC_IDLE);
    assign resp_valid_o = (state_q == DC_RESP);
    assign resp_rdata_o = rdata_q;

    // One word per transaction, request dropped once accepted
    assign mem.req_valid  = ((state_q == DC_RD) || (state_q == DC_WR)) && !sent_q;
    assign mem.req_addr   = addr_q;
    assign mem.req_we     = (state_q == DC_WR);
    assign mem.req_wdata  = wdata_q;
    assign mem.req_len    = '0;
    assign mem.resp_ready = sent_q;

    assign req_fire  = mem.req_valid && mem.req_ready;
    assign resp_done = mem.resp_valid && mem.resp_ready && mem.resp_last;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DC_IDLE;
            sent_q  <= 1'b0;
        end else begin
            if (req_fire) begin
                sent_q <= 1'b1;
            end
            unique case (state_q)
                DC_IDLE: begin
                    if (req_valid_i) begin
                        if (req_op_i == DC_STORE) begin
                            state_q <= DC_WR;
                        end else begin
                            state_q <= DC_RD;
                        end
                    end
                end
                DC_RD: begin
                    if (resp_done) begin
                        sent_q <= 1'b0;
                        // Atomic add goes on to write back the sum
                        if (op_q == DC_AMOADD) begin
                            state_q <= DC_WR;
                        end else begin
                            state_q <= DC_RESP;
                        end
                    end
                end
                DC_WR: begin
                    if (resp_done) begin
                        sent_q  <= 1'b0;
                        state_q <= DC_RESP;
                    end
                end
                DC_RESP: begin
                    if (resp_ready_i) begin
                        state_q <= DC_IDLE;
                    end
                end
                default: state_q <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
        if (resp_done && (state_q == DC_RD)) begin
            // Old value is the result, old plus operand is written back
            rdata_q <= mem.resp_data;
            wdata_q <= mem.resp_data + wdata_q;
        end else if (resp_done && (op_q == DC_STORE)) begin
            rdata_q <= '0;
        end
    end

    a_resp_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o)
    );

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// Round-robin arbiter between the instruction and data ports
// One transaction in flight, registered request, response steered by owner

`default_nettype none

module mem_arbiter (
    input  logic                              clk_i,
    input  logic                              rst_i,
    mem_port_if.arb                           ic,
    mem_port_if.arb                           dc,
    // Memory request bus
    output logic                              mem_req_valid_o,
    input  logic                              mem_req_ready_i,
    output logic [mem_bridge_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic                              mem_req_we_o,
    output logic [mem_bridge_pkg::DATA_W-1:0] mem_req_wdata_o,
    output logic [mem_bridge_pkg::BEAT_W-1:0] mem_req_len_o,
    output mem_bridge_pkg::mem_src_e          mem_req_src_o,
    // Tagged burst response
    input  logic                              mem_resp_valid_i,
    output logic                              mem_resp_ready_o,
    input  logic [mem_bridge_pkg::DATA_W-1:0] mem_resp_data_i,
    input  logic                              mem_resp_last_i,
    input  mem_bridge_pkg::mem_src_e          mem_resp_src_i
);
    import mem_bridge_pkg::*;

    arb_state_e state_q;
    // Owner of the current transaction, also the last one granted
    mem_src_e   owner_q;
    logic       grant_dc;
    logic       any_req;
    logic       own_ic;
    logic       own_dc;

    assign any_req = ic.req_valid || dc.req_valid;

    // On a tie the port not granted last wins
    always_comb begin
        if (ic.req_valid && dc.req_valid) begin
            grant_dc = (owner_q == SRC_ICACHE);
        end else begin
            grant_dc = dc.req_valid;
        end
    end

    assign ic.req_ready = (state_q == ARB_IDLE) && !grant_dc;
    assign dc.req_ready = (state_q == ARB_IDLE) && grant_dc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q         <= ARB_IDLE;
            owner_q         <= SRC_DCACHE;
            mem_req_valid_o <= 1'b0;
        end else begin
            unique case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        owner_q         <= grant_dc ? SRC_DCACHE : SRC_ICACHE;
                        mem_req_valid_o <= 1'b1;
                        state_q         <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (mem_req_ready_i) begin
                        mem_req_valid_o <= 1'b0;
                        state_q         <= ARB_RESP;
                    end
                end
                ARB_RESP: begin
                    if (mem_resp_valid_i && mem_resp_ready_o && mem_resp_last_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Request fields captured at grant
    always_ff @(posedge clk_i) begin
        if ((state_q == ARB_IDLE) && any_req) begin
            mem_req_addr_o  <= grant_dc ? dc.req_addr  : ic.req_addr;
            mem_req_we_o    <= grant_dc ? dc.req_we    : ic.req_we;
            mem_req_wdata_o <= grant_dc ? dc.req_wdata : ic.req_wdata;
            mem_req_len_o   <= grant_dc ? dc.req_len   : ic.req_len;
        end
    end

    assign mem_req_src_o = owner_q;

    // Response steering
    assign own_ic = (state_q == ARB_RESP) && (owner_q == SRC_ICACHE);
    assign own_dc = (state_q == ARB_RESP) && (owner_q == SRC_DCACHE);

    assign ic.resp_valid = own_ic && mem_resp_valid_i;
    assign ic.resp_data  = mem_resp_data_i;
    assign ic.resp_last  = mem_resp_last_i;
    assign dc.resp_valid = own_dc && mem_resp_valid_i;
    assign dc.resp_data  = mem_resp_data_i;
    assign dc.resp_last  = mem_resp_last_i;

    assign mem_resp_ready_o = (own_ic && ic.resp_ready) || (own_dc && dc.resp_ready);

    a_req_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
    );

    // Memory must only answer the transaction in flight
    a_resp_owner: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_resp_valid_i |-> (state_q == ARB_RESP) && (mem_resp_src_i == owner_q)
    );

endmodule

`default_nettype wire

// File: design/mem_bridge.sv
// Memory-side bridge top level
// Icache refill port and uncached data port merged onto one memory bus

`default_nettype none

module mem_bridge (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    // Instruction miss and refill beats
    input  logic                                   icache_miss_valid_i,
    input  logic [mem_bridge_pkg::LINE_ADDR_W-1:0] icache_miss_line_i,
    output logic                                   icache_resp_valid_o,
    output logic [mem_bridge_pkg::DATA_W-1:0]      icache_resp_data_o,
    output logic [mem_bridge_pkg::BEAT_W-1:0]      icache_resp_beat_o,
    // Uncached data requests
    input  logic                                   dc_req_valid_i,
    output logic                                   dc_req_ready_o,
    input  mem_bridge_pkg::dc_op_e                 dc_req_op_i,
    input  logic [mem_bridge_pkg::ADDR_W-1:0]      dc_req_addr_i,
    input  logic [mem_bridge_pkg::DATA_W-1:0]      dc_req_wdata_i,
    output logic                                   dc_resp_valid_o,
    input  logic                                   dc_resp_ready_i,
    output logic [mem_bridge_pkg::DATA_W-1:0]      dc_resp_rdata_o,
    // Memory bus
    output logic                                   mem_req_valid_o,
    input  logic                                   mem_req_ready_i,
    output logic [mem_bridge_pkg::ADDR_W-1:0]      mem_req_addr_o,
    output logic                                   mem_req_we_o,
    output logic [mem_bridge_pkg::DATA_W-1:0]      mem_req_wdata_o,
    output logic [mem_bridge_pkg::BEAT_W-1:0]      mem_req_len_o,
    output mem_bridge_pkg::mem_src_e               mem_req_src_o,
    input  logic                                   mem_resp_valid_i,
    output logic                                   mem_resp_ready_o,
    input  logic [mem_bridge_pkg::DATA_W-1:0]      mem_resp_data_i,
    input  logic                                   mem_resp_last_i,
    input  mem_bridge_pkg::mem_src_e               mem_resp_src_i
);

    mem_port_if ic_if ();
    mem_port_if dc_if ();

    icache_refill_port u_icache_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .miss_valid_i (icache_miss_valid_i),
        .miss_line_i  (icache_miss_line_i),
        .beat_valid_o (icache_resp_valid_o),
        .beat_data_o  (icache_resp_data_o),
        .beat_idx_o   (icache_resp_beat_o),
        .mem          (ic_if.port)
    );

    dcache_uc_port u_dcache_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (dc_req_valid_i),
        .req_ready_o  (dc_req_ready_o),
        .req_op_i     (dc_req_op_i),
        .req_addr_i   (dc_req_addr_i),
        .req_wdata_i  (dc_req_wdata_i),
        .resp_valid_o (dc_resp_valid_o),
        .resp_ready_i (dc_resp_ready_i),
        .resp_rdata_o (dc_resp_rdata_o),
        .mem          (dc_if.port)
    );

    mem_arbiter u_arbiter (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .ic               (ic_if.arb),
        .dc               (dc_if.arb),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_we_o     (mem_req_we_o),
        .mem_req_wdata_o  (mem_req_wdata_o),
        .mem_req_len_o    (mem_req_len_o),
        .mem_req_src_o    (mem_req_src_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_data_i  (mem_resp_data_i),
        .mem_resp_last_i  (mem_resp_last_i),
        .mem_resp_src_i   (mem_resp_src_i)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock of 8 ns period
// Reset held high for the first 3 rising edges

`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_mem_model.sv
// Memory responder for the bridge bus, 256 words
// Random request ready, random 0 to 3 cycle delay before each beat

`default_nettype none

module tb_mem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  logic [31:0] req_addr_i,
    input  logic        req_we_i,
    input  logic [31:0] req_wdata_i,
    input  logic [1:0]  req_len_i,
    input  logic        req_src_i,
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output logic [31:0] resp_data_o,
    output logic        resp_last_o,
    output logic        resp_src_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [256];
    logic [7:0]  word_idx;
    logic        we_q;
    int          beats_left;
    int          delay;
    int          phase;

    // Every bit of the word index shows up in the data
    function automatic logic [31:0] word_pattern(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_pattern(8'(i));
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            req_ready_o  <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_last_o  <= 1'b0;
            resp_data_o  <= '0;
            resp_src_o   <= 1'b0;
            phase        <= 0;
        end else begin
            case (phase)
                // Accept a request
                0: begin
                    req_ready_o <= 1'($urandom_range(0, 1));
                    if (req_valid_i && req_ready_o) begin
                        req_ready_o <= 1'b0;
                        word_idx    <= req_addr_i[9:2];
                        we_q        <= req_we_i;
                        resp_src_o  <= req_src_i;
                        if (req_we_i) begin
                            mem[req_addr_i[9:2]] = req_wdata_i;
                        end
                        beats_left <= req_we_i ? 0 : int'(req_len_i);
                        delay      <= $urandom_range(0, 3);
                        phase      <= 1;
                    end
                end
                // Delay before the next beat
                1: begin
                    if (delay == 0) begin
                        resp_valid_o <= 1'b1;
                        resp_data_o  <= we_q ? 32'h0 : mem[word_idx];
                        resp_last_o  <= (beats_left == 0);
                        phase        <= 2;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                // Beat held until taken
                default: begin
                    if (resp_ready_i) begin
                        resp_valid_o <= 1'b0;
                        resp_last_o  <= 1'b0;
                        if (beats_left == 0) begin
                            phase <= 0;
                        end else begin
                            word_idx   <= word_idx + 8'd1;
                            beats_left <= beats_left - 1;
                            delay      <= $urandom_range(0, 3);
                            phase      <= 1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_mem_bridge.sv
// Testbench top for the memory bridge
// Stimulus tasks, shadow memory with reference functions, checker and summary

`default_nettype none

module tb_mem_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_bridge_pkg::*;

    // Bus transactions over all tests, atomics counted twice
    localparam int NUM_TXN     = 50;
    localparam int CYCLE_LIMIT = 40 * NUM_TXN + 200;

    logic clk;
    logic rst;
    logic ic_miss_valid;
    logic [LINE_ADDR_W-1:0] ic_miss_line;
    logic ic_resp_valid;
    logic [DATA_W-1:0] ic_resp_data;
    logic [BEAT_W-1:0] ic_resp_beat;
    logic dc_req_valid;
    logic dc_req_ready;
    dc_op_e dc_req_op;
    logic [ADDR_W-1:0] dc_req_addr;
    logic [DATA_W-1:0] dc_req_wdata;
    logic dc_resp_valid;
    logic dc_resp_ready;
    logic [DATA_W-1:0] dc_resp_rdata;
    logic mem_req_valid;
    logic mem_req_ready;
    logic [ADDR_W-1:0] mem_req_addr;
    logic mem_req_we;
    logic [DATA_W-1:0] mem_req_wdata;
    logic [BEAT_W-1:0] mem_req_len;
    mem_src_e mem_req_src;
    logic mem_resp_valid;
    logic mem_resp_ready;
    logic [DATA_W-1:0] mem_resp_data;
    logic mem_resp_last;
    mem_src_e mem_resp_src;
    logic model_resp_src;

    logic [31:0] shadow [256];
    logic [31:0] ic_data_q [$];
    logic [1:0]  ic_idx_q [$];
    logic [31:0] dc_exp_q [$];
    int  cycles;
    int  errors;
    int  test_req;
    int  test_resp;
    int  tests;
    int  failed;
    int  in_flight;
    logic bp_mode;

    assign mem_resp_src = mem_src_e'(model_resp_src);

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    tb_mem_model u_model (
        .clk_i(clk), .rst_i(rst),
        .req_valid_i(mem_req_valid), .req_ready_o(mem_req_ready),
        .req_addr_i(mem_req_addr), .req_we_i(mem_req_we),
        .req_wdata_i(mem_req_wdata), .req_len_i(mem_req_len),
        .req_src_i(mem_req_src),
        .resp_valid_o(mem_resp_valid), .resp_ready_i(mem_resp_ready),
        .resp_data_o(mem_resp_data), .resp_last_o(mem_resp_last),
        .resp_src_o(model_resp_src)
    );

    mem_bridge u_mem_bridge (
        .clk_i(clk), .rst_i(rst),
        .icache_miss_valid_i(ic_miss_valid), .icache_miss_line_i(ic_miss_line),
        .icache_resp_valid_o(ic_resp_valid), .icache_resp_data_o(ic_resp_data),
        .icache_resp_beat_o(ic_resp_beat),
        .dc_req_valid_i(dc_req_valid), .dc_req_ready_o(dc_req_ready),
        .dc_req_op_i(dc_req_op), .dc_req_addr_i(dc_req_addr),
        .dc_req_wdata_i(dc_req_wdata), .dc_resp_valid_o(dc_resp_valid),
        .dc_resp_ready_i(dc_resp_ready), .dc_resp_rdata_o(dc_resp_rdata),
        .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
        .mem_req_addr_o(mem_req_addr), .mem_req_we_o(mem_req_we),
        .mem_req_wdata_o(mem_req_wdata), .mem_req_len_o(mem_req_len),
        .mem_req_src_o(mem_req_src), .mem_resp_valid_i(mem_resp_valid),
        .mem_resp_ready_o(mem_resp_ready), .mem_resp_data_i(mem_resp_data),
        .mem_resp_last_i(mem_resp_last), .mem_resp_src_i(mem_resp_src)
    );

    // Initial memory contents, a function of the word index
    function automatic logic [31:0] word_pattern(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
    endfunction

    // Expected refill word for one beat of a line
    function automatic logic [31:0] exp_line(input logic [LINE_ADDR_W-1:0] line,
                                             input logic [1:0] beat);
        return shadow[{line[5:0], beat}];
    endfunction

    // Expected data response, zero for a store, old word otherwise
    function automatic logic [31:0] exp_dc(input dc_op_e op, input logic [31:0] addr);
        if (op == DC_STORE) begin
            return 32'h0;
        end
        return shadow[addr[9:2]];
    endfunction

    // Checker and reference update at every edge
    always @(posedge clk) begin
        logic [31:0] exp;
        logic [1:0]  idx;
        mem_src_e    src;
        if (!rst) begin
            if (mem_resp_valid && mem_resp_ready && mem_resp_last) begin
                in_flight = 0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (in_flight != 0) begin
                    $display("Error at %0t: two transactions in flight on the bus", $time);
                    errors++;
                end
                in_flight = 1;
                // Only a refill reads a whole line in one burst
                if (!mem_req_we && mem_req_len == 2'(LINE_BEATS - 1)) begin
                    src = SRC_ICACHE;
                end else begin
                    src = SRC_DCACHE;
                end
                if (mem_req_src !== src) begin
                    $display("MISMATCH at %0t: request source %0d, expected %0d",
                             $time, mem_req_src, src);
                    errors++;
                end
            end
            if (ic_miss_valid) begin
                for (int b = 0; b < LINE_BEATS; b++) begin
                    ic_data_q.push_back(exp_line(ic_miss_line, 2'(b)));
                    ic_idx_q.push_back(2'(b));
                end
                test_req++;
            end
            if (ic_resp_valid) begin
                if (ic_data_q.size() == 0) begin
                    $display("Error at %0t: icache beat with no miss pending", $time);
                    errors++;
                end else begin
                    exp = ic_data_q.pop_front();
                    idx = ic_idx_q.pop_front();
                    if (ic_resp_data !== exp || ic_resp_beat !== idx) begin
                        $display("MISMATCH at %0t: icache beat %0d data %h, expected beat %0d %h",
                                 $time, ic_resp_beat, ic_resp_data, idx, exp);
                        errors++;
                    end
                end
                // A line is answered by its final beat
                if (ic_resp_beat == 2'(LINE_BEATS - 1)) begin
                    test_resp++;
                end
            end
            if (dc_req_valid && dc_req_ready) begin
                dc_exp_q.push_back(exp_dc(dc_req_op, dc_req_addr));
                if (dc_req_op == DC_STORE) begin
                    shadow[dc_req_addr[9:2]] = dc_req_wdata;
                end else if (dc_req_op == DC_AMOADD) begin
                    shadow[dc_req_addr[9:2]] = shadow[dc_req_addr[9:2]] + dc_req_wdata;
                end
                test_req++;
            end
            if (dc_resp_valid && dc_resp_ready) begin
                if (dc_exp_q.size() == 0) begin
                    $display("Error at %0t: data response with no request pending", $time);
                    errors++;
                end else begin
                    exp = dc_exp_q.pop_front();
                    if (dc_resp_rdata !== exp) begin
                        $display("MISMATCH at %0t: data response %h, expected %h",
                                 $time, dc_resp_rdata, exp);
                        errors++;
                    end
                end
                test_resp++;
            end
        end
    end

    always @(posedge clk) begin
        dc_resp_ready <= bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic issue_dc(input dc_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        dc_req_valid <= 1'b1;
        dc_req_op    <= op;
        dc_req_addr  <= addr;
        dc_req_wdata <= wdata;
        @(posedge clk);
        while (!dc_req_ready) @(posedge clk);
        dc_req_valid <= 1'b0;
    endtask

    // One strobe, only once the previous line has fully returned
    task automatic issue_miss(input logic [LINE_ADDR_W-1:0] line);
        while (ic_data_q.size() != 0) @(posedge clk);
        ic_miss_valid <= 1'b1;
        ic_miss_line  <= line;
        @(posedge clk);
        ic_miss_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (ic_data_q.size() != 0 || dc_exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        wait_done();
        if (test_req != test_resp) begin
            $display("Error: %s got %0d responses for %0d requests", name, test_resp, test_req);
            errors++;
        end
        $display("%s: requests %0d responses %0d errors %0d", name, test_req, test_resp,
                 errors - errs_before);
        tests++;
        if (errors != errs_before) begin
            failed++;
        end
        test_req  = 0;
        test_resp = 0;
    endtask

    initial begin
        int e;
        logic [31:0] v;
        process_seed: begin
            void'($urandom(32'h1f62f4ac));
        end
        ic_miss_valid = 1'b0;
        ic_miss_line  = '0;
        dc_req_valid  = 1'b0;
        dc_req_op     = DC_LOAD;
        dc_req_addr   = '0;
        dc_req_wdata  = '0;
        dc_resp_ready = 1'b0;
        bp_mode       = 1'b0;
        cycles = 0;
        errors = 0;
        tests = 0;
        failed = 0;
        in_flight = 0;
        test_req = 0;
        test_resp = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = word_pattern(8'(i));
        end

        @(posedge clk);
        while (rst) @(posedge clk);
        e = errors;
        if (ic_resp_valid || dc_resp_valid || mem_req_valid || mem_resp_ready
                || !dc_req_ready) begin
            $display("Error at %0t: outputs not in their reset state", $time);
            errors++;
        end
        finish_test("reset", e);

        e = errors;
        issue_miss(28'd2);
        issue_miss(28'd5);
        finish_test("icache refill", e);

        // Data tests use words 128 and up, refills stay below
        e = errors;
        v = $urandom;
        issue_dc(DC_STORE, 32'h200, v);
        issue_dc(DC_LOAD, 32'h200, 32'h0);
        finish_test("load and store", e);

        e = errors;
        issue_dc(DC_AMOADD, 32'h204, 32'hfff0_0000 + 32'($urandom_range(0, 255)));
        issue_dc(DC_LOAD, 32'h204, 32'h0);
        finish_test("atomic add", e);

        e = errors;
        fork
            begin
                issue_miss(28'd0);
                issue_miss(28'd7);
                issue_miss(28'd12);
                issue_miss(28'd31);
            end
            begin
                issue_dc(DC_STORE, 32'h300, $urandom);
                issue_dc(DC_AMOADD, 32'h300, $urandom);
                issue_dc(DC_LOAD, 32'h300, 32'h0);
                issue_dc(DC_AMOADD, 32'h308, $urandom);
                issue_dc(DC_LOAD, 32'h308, 32'h0);
                issue_dc(DC_LOAD, 32'h3fc, 32'h0);
            end
        join
        finish_test("both ports", e);

        e = errors;
        bp_mode = 1'b1;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    issue_miss(28'($urandom_range(0, 31)));
                end
            end
            begin
                for (int i = 0; i < 12; i++) begin
                    issue_dc(dc_op_e'($urandom_range(0, 2)),
                             {22'h0, 2'b10, 6'($urandom_range(0, 63)), 2'b00}, $urandom);
                end
            end
        join
        finish_test("back-pressure", e);
        bp_mode = 1'b0;

        $display("tests %0d failed %0d errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_bridge.f
design/mem_bridge_pkg.sv
design/mem_port_if.sv
design/icache_refill_port.sv
design/dcache_uc_port.sv
design/mem_arbiter.sv
design/mem_bridge.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_mem_bridge.sv

// File: Makefile
# Verilator build and run of the mem_bridge testbench

TOP := tb_mem_bridge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mem_bridge.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
